// ==== hw/la32_isa_pkg.sv ====
`default_nettype none

package la32_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  excp_code_t;

    localparam excp_code_t EXC_NONE = 6'h00;
    localparam excp_code_t EXC_ADEF = 6'h08;  // Fetch address error
    localparam excp_code_t EXC_SYS  = 6'h0B;
    localparam excp_code_t EXC_BRK  = 6'h0C;
    localparam excp_code_t EXC_INE  = 6'h0D;  // Unknown encoding

    // Major opcode in ir[31:26]
    localparam logic [5:0] OPC_ARITH     = 6'b000000;
    localparam logic [5:0] OPC_LU12I     = 6'b000101;
    localparam logic [5:0] OPC_PCADDU12I = 6'b000111;
    localparam logic [5:0] OPC_LDST      = 6'b001010;
    localparam logic [5:0] OPC_JIRL      = 6'b010011;
    localparam logic [5:0] OPC_B         = 6'b010100;
    localparam logic [5:0] OPC_BL        = 6'b010101;
    localparam logic [5:0] OPC_BEQ       = 6'b010110;
    localparam logic [5:0] OPC_BNE       = 6'b010111;
    localparam logic [5:0] OPC_BLT       = 6'b011000;
    localparam logic [5:0] OPC_BGE       = 6'b011001;
    localparam logic [5:0] OPC_BLTU      = 6'b011010;
    localparam logic [5:0] OPC_BGEU      = 6'b011011;

    // 3R function code in ir[21:15]
    localparam logic [6:0] FN_ADD_W   = 7'b0100000;
    localparam logic [6:0] FN_SUB_W   = 7'b0100010;
    localparam logic [6:0] FN_SLT     = 7'b0100100;
    localparam logic [6:0] FN_SLTU    = 7'b0100101;
    localparam logic [6:0] FN_NOR     = 7'b0101000;
    localparam logic [6:0] FN_AND     = 7'b0101001;
    localparam logic [6:0] FN_OR      = 7'b0101010;
    localparam logic [6:0] FN_XOR     = 7'b0101011;
    localparam logic [6:0] FN_SLL_W   = 7'b0101110;
    localparam logic [6:0] FN_SRL_W   = 7'b0101111;
    localparam logic [6:0] FN_SRA_W   = 7'b0110000;
    localparam logic [6:0] FN_BREAK   = 7'b1010100;
    localparam logic [6:0] FN_SYSCALL = 7'b1010110;

endpackage

`default_nettype wire

// ==== hw/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    typedef enum logic [3:0] {
        UNIT_ALU  = 4'd0,
        UNIT_BR   = 4'd1,
        UNIT_EXCP = 4'd3,
        UNIT_MEM  = 4'd5,
        UNIT_LINK = 4'd8   // Branch that also writes a link register
    } unit_t;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_NOR    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_SLTU   = 4'd10,
        ALU_PASS_A = 4'd11,
        ALU_PASS_B = 4'd12
    } alu_op_t;

    typedef enum logic [2:0] {
        JK_NOT_JUMP = 3'd0,
        JK_DIRECT   = 3'd1,
        JK_JUMP     = 3'd2,
        JK_CALL     = 3'd3,
        JK_RET      = 3'd4,
        JK_INDIRECT = 3'd5
    } jump_kind_t;

    typedef struct packed {
        logic       valid;
        logic       use_rd;
        jump_kind_t kind;
        alu_op_t    aluop;
        logic [1:0] pcsrc;
        logic [1:0] alusrc1;
        logic [1:0] alusrc2;
        logic [4:0] subtype;
        logic       regwrite;
        logic       memwrite;
        logic       memread;
        unit_t      unit;
        logic [4:0] pad;
    } ctrl_t;

    localparam logic [1:0] PCSRC_BR  = 2'd1;
    localparam logic [1:0] SRC1_PC   = 2'd1;
    localparam logic [1:0] SRC2_IMM  = 2'd1;
    localparam logic [1:0] SRC2_CMP  = 2'd2;  // Compare rj against rd
    localparam logic [1:0] SRC2_FOUR = 2'd3;  // Link address pc + 4

    localparam logic [4:0] SUB_B    = 5'd0;
    localparam logic [4:0] SUB_JIRL = 5'd0;
    localparam logic [4:0] SUB_BL   = 5'd1;

    typedef logic [4:0] apb_addr_t;

    localparam apb_addr_t ADDR_PC   = 5'h00;
    localparam apb_addr_t ADDR_IR   = 5'h04;
    localparam apb_addr_t ADDR_CTRL = 5'h08;
    localparam apb_addr_t ADDR_IMM  = 5'h0C;
    localparam apb_addr_t ADDR_REGS = 5'h10;

endpackage

`default_nettype wire

// ==== hw/stage_ifs.sv ====
`default_nettype none

interface field_if;
    import la32_isa_pkg::*;

    logic        valid;
    logic [31:0] pc;
    instr_t      ir;
    logic        misaligned;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;

    modport src (output valid, pc, ir, misaligned, rd, rj, rk);
    modport dst (input valid, pc, ir, misaligned, rd, rj, rk);
endinterface

interface uop_if;
    import la32_isa_pkg::*;
    import decode_pkg::*;

    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] imm;
    excp_code_t  excp;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic        off_zero;  // JIRL offset field is zero

    modport src (output valid, ctrl, imm, excp, rd, rj, rk, off_zero);
    modport dst (input valid, ctrl, imm, excp, rd, rj, rk, off_zero);
endinterface

`default_nettype wire

// ==== hw/fetch_check.sv ====
`default_nettype none

module fetch_check (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       launch,
    input  wire [31:0]                pc,
    input  wire la32_isa_pkg::instr_t ir,
    field_if.src                      f
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            f.valid <= 1'b0;
        else
            f.valid <= launch;
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            f.pc <= pc;
            f.ir <= ir;
        end
    end

    // Word fetch needs pc[1:0] clear
    assign f.misaligned = |f.pc[1:0];

    assign f.rd = f.ir[4:0];
    assign f.rj = f.ir[9:5];
    assign f.rk = f.ir[14:10];

endmodule

`default_nettype wire

// ==== hw/op_decode.sv ====
`default_nettype none

module op_decode (
    input  wire  clk,
    input  wire  arst_n,
    field_if.dst f,
    uop_if.src   u
);
    import la32_isa_pkg::*;
    import decode_pkg::*;

    instr_t      ir;
    ctrl_t       c;
    logic [31:0] imm;
    excp_code_t  excp;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic        ine;
    logic [31:0] imm_si12;
    logic [31:0] imm_ui12;
    logic [31:0] imm_ui5;
    logic [31:0] imm_hi20;
    logic [31:0] imm_off16;
    logic [31:0] imm_off26;

    assign ir        = f.ir;
    assign imm_si12  = {{20{ir[21]}}, ir[21:10]};
    assign imm_ui12  = {20'b0, ir[21:10]};
    assign imm_ui5   = {27'b0, ir[14:10]};
    assign imm_hi20  = {ir[24:5], 12'b0};
    assign imm_off16 = {{14{ir[25]}}, ir[25:10], 2'b0};
    assign imm_off26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b0};  // High half sits in ir[9:0]

    always_comb
    begin
        c    = '0;
        imm  = '0;
        excp = EXC_NONE;
        rd   = '0;
        rj   = '0;
        rk   = '0;
        ine  = 1'b0;
        case (ir[31:26])
            OPC_ARITH:
            begin
                rd         = f.rd;
                rj         = f.rj;
                c.regwrite = 1'b1;
                if (ir[25:22] != 4'b0000)
                    c.alusrc2 = SRC2_IMM;
                if (ir[25])
                    imm = ir[24] ? imm_ui12 : imm_si12;  // Logic ops zero-extend
                else if (ir[22])
                    imm = imm_ui5;
                case (ir[25:22])
                    4'b0000:
                    begin
                        rk = f.rk;
                        case (ir[21:15])
                            FN_ADD_W:   c.aluop = ALU_ADD;
                            FN_SUB_W:   c.aluop = ALU_SUB;
                            FN_SLT:     c.aluop = ALU_SLT;
                            FN_SLTU:    c.aluop = ALU_SLTU;
                            FN_NOR:     c.aluop = ALU_NOR;
                            FN_AND:     c.aluop = ALU_AND;
                            FN_OR:      c.aluop = ALU_OR;
                            FN_XOR:     c.aluop = ALU_XOR;
                            FN_SLL_W:   c.aluop = ALU_SLL;
                            FN_SRL_W:   c.aluop = ALU_SRL;
                            FN_SRA_W:   c.aluop = ALU_SRA;
                            FN_BREAK:   excp = EXC_BRK;
                            FN_SYSCALL: excp = EXC_SYS;
                            default:    ine = 1'b1;
                        endcase
                    end
                    4'b0001:
                        case ({ir[21:20], ir[19:18], ir[17:15]})
                            7'b00_00_001: c.aluop = ALU_SLL;  // SLLI.W
                            7'b00_01_001: c.aluop = ALU_SRL;
                            7'b00_10_001: c.aluop = ALU_SRA;
                            default:      ine = 1'b1;
                        endcase
                    4'b1000: c.aluop = ALU_SLT;   // SLTI
                    4'b1001: c.aluop = ALU_SLTU;
                    4'b1010: c.aluop = ALU_ADD;   // ADDI.W
                    4'b1101: c.aluop = ALU_AND;
                    4'b1110: c.aluop = ALU_OR;
                    4'b1111: c.aluop = ALU_XOR;
                    default: ine = 1'b1;
                endcase
            end
            OPC_LU12I, OPC_PCADDU12I:
            begin
                rd         = f.rd;
                imm        = imm_hi20;
                c.regwrite = 1'b1;
                c.alusrc2  = SRC2_IMM;
                c.aluop    = ir[27] ? ALU_ADD : ALU_PASS_B;  // PCADDU12I adds pc
                c.alusrc1  = ir[27] ? SRC1_PC : 2'd0;
                ine        = ir[25];
            end
            OPC_LDST:
            begin
                rd         = f.rd;
                rj         = f.rj;
                imm        = imm_si12;
                c.unit     = UNIT_MEM;
                c.memwrite = ~ir[25] & ir[24];
                c.use_rd   = ~ir[25] & ir[24];  // Store data comes from rd
                c.memread  = ~c.memwrite;
                c.regwrite = ~c.memwrite;
                case (ir[25:22])
                    4'b0000: c.subtype = 5'd0;  // LD.B
                    4'b0001: c.subtype = 5'd1;
                    4'b0010: c.subtype = 5'd2;
                    4'b0100: c.subtype = 5'd3;  // ST.B
                    4'b0101: c.subtype = 5'd4;
                    4'b0110: c.subtype = 5'd5;
                    4'b1000: c.subtype = 5'd6;  // LD.BU
                    4'b1001: c.subtype = 5'd7;
                    default: ine = 1'b1;
                endcase
            end
            OPC_JIRL:
            begin
                rd         = f.rd;
                rj         = f.rj;
                imm        = imm_off16;
                c.unit     = UNIT_LINK;
                c.subtype  = SUB_JIRL;
                c.regwrite = 1'b1;
                c.pcsrc    = PCSRC_BR;
                c.aluop    = ALU_ADD;
                c.alusrc1  = SRC1_PC;
                c.alusrc2  = SRC2_FOUR;
                c.use_rd   = 1'b1;
            end
            OPC_BL:
            begin
                rd         = 5'd1;  // Implicit ra
                imm        = imm_off26;
                c.unit     = UNIT_LINK;
                c.subtype  = SUB_BL;
                c.regwrite = 1'b1;
                c.pcsrc    = PCSRC_BR;
                c.aluop    = ALU_ADD;
                c.alusrc1  = SRC1_PC;
                c.alusrc2  = SRC2_FOUR;
                c.use_rd   = 1'b1;
            end
            OPC_B:
            begin
                imm       = imm_off26;
                c.unit    = UNIT_BR;
                c.subtype = SUB_B;
                c.pcsrc   = PCSRC_BR;
            end
            OPC_BEQ, OPC_BNE, OPC_BLT, OPC_BGE, OPC_BLTU, OPC_BGEU:
            begin
                rd        = f.rd;
                rj        = f.rj;
                imm       = imm_off16;
                c.unit    = UNIT_BR;
                c.subtype = {2'b00, ir[28:26] + 3'd3};  // BEQ 1 up to BGEU 6
                c.pcsrc   = PCSRC_BR;
                c.alusrc2 = SRC2_CMP;
                c.use_rd  = 1'b1;
                case (ir[28:27])
                    2'b11:   c.aluop = ALU_SUB;  // BEQ, BNE
                    2'b00:   c.aluop = ALU_SLT;
                    default: c.aluop = ALU_SLTU;
                endcase
            end
            default: ine = 1'b1;
        endcase

        // Exceptions carry nothing but the code
        if (f.misaligned)
            excp = EXC_ADEF;
        else if (ine)
            excp = EXC_INE;
        if (excp != EXC_NONE)
        begin
            c      = '0;
            c.unit = UNIT_EXCP;
            imm    = '0;
            rd     = '0;
            rj     = '0;
            rk     = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            u.valid <= 1'b0;
        else
            u.valid <= f.valid;
    end

    always_ff @(posedge clk)
    begin
        if (f.valid)
        begin
            u.ctrl     <= c;
            u.imm      <= imm;
            u.excp     <= excp;
            u.rd       <= rd;
            u.rj       <= rj;
            u.rk       <= rk;
            u.off_zero <= (ir[25:10] == 16'd0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/jump_classify.sv ====
`default_nettype none

module jump_classify (
    input  wire                 clk,
    input  wire                 arst_n,
    uop_if.dst                  u,
    output logic                res_valid,
    output decode_pkg::ctrl_t   res_ctrl,
    output logic [31:0]         res_imm,
    output logic [31:0]         res_regs
);
    import decode_pkg::*;

    jump_kind_t kind;
    ctrl_t      ctrl_d;

    always_comb
    begin
        kind = JK_NOT_JUMP;
        if (u.ctrl.unit == UNIT_LINK && u.ctrl.subtype == SUB_JIRL)
        begin
            if (u.rd == 5'd0 && u.rj == 5'd1 && u.off_zero)
                kind = JK_RET;     // jirl r0, ra, 0
            else if (u.rd == 5'd1)
                kind = JK_CALL;
            else
                kind = JK_INDIRECT;
        end
        else if (u.ctrl.unit == UNIT_LINK)
            kind = JK_CALL;        // BL
        else if (u.ctrl.unit == UNIT_BR && u.ctrl.subtype == SUB_B)
            kind = JK_JUMP;
        else if (u.ctrl.unit == UNIT_BR)
            kind = JK_DIRECT;

        ctrl_d       = u.ctrl;
        ctrl_d.valid = 1'b1;
        ctrl_d.kind  = kind;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            res_valid <= 1'b0;
        else
            res_valid <= u.valid;
    end

    always_ff @(posedge clk)
    begin
        if (u.valid)
        begin
            res_ctrl <= ctrl_d;
            res_imm  <= u.imm;
            res_regs <= {11'b0, u.excp, u.rk, u.rj, u.rd};
        end
    end

endmodule

`default_nettype wire

// ==== hw/decoder_apb.sv ====
`default_nettype none

module decoder_apb (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire decode_pkg::apb_addr_t paddr,
    input  wire [31:0]            pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);
    import decode_pkg::*;

    logic [31:0] pc_q;
    logic        wr_done;
    logic        launch;
    logic        rd_ok;
    logic        wr_ok;
    logic        result_rd;
    logic        busy;
    logic        res_valid;
    ctrl_t       res_ctrl;
    logic [31:0] res_imm;
    logic [31:0] res_regs;
    ctrl_t       res_ctrl_q;
    logic [31:0] res_imm_q;
    logic [31:0] res_regs_q;

    field_if f_if ();
    uop_if   u_if ();

    fetch_check u_fetch (
        .clk    (clk),
        .arst_n (arst_n),
        .launch (launch),
        .pc     (pc_q),
        .ir     (pwdata),
        .f      (f_if.src)
    );

    op_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .f      (f_if.dst),
        .u      (u_if.src)
    );

    jump_classify u_jump (
        .clk       (clk),
        .arst_n    (arst_n),
        .u         (u_if.dst),
        .res_valid (res_valid),
        .res_ctrl  (res_ctrl),
        .res_imm   (res_imm),
        .res_regs  (res_regs)
    );

    assign wr_done = psel & penable & pwrite;  // Writes never wait
    assign launch  = wr_done & (paddr == ADDR_IR);

    assign wr_ok     = (paddr == ADDR_PC) || (paddr == ADDR_IR);
    assign result_rd = (paddr == ADDR_CTRL) || (paddr == ADDR_IMM) || (paddr == ADDR_REGS);
    assign busy      = f_if.valid | u_if.valid | res_valid;

    // Result reads wait for the pipeline to drain
    assign pready  = ~(psel & ~pwrite & result_rd & busy);
    assign pslverr = psel & penable & ~(pwrite ? wr_ok : rd_ok);

    always_comb
    begin
        prdata = '0;
        rd_ok  = 1'b1;
        case (paddr)
            ADDR_PC:   prdata = pc_q;
            ADDR_CTRL: prdata = res_ctrl_q;
            ADDR_IMM:  prdata = res_imm_q;
            ADDR_REGS: prdata = res_regs_q;
            default:   rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_q       <= '0;
            res_ctrl_q <= '0;
            res_imm_q  <= '0;
            res_regs_q <= '0;
        end
        else
        begin
            if (wr_done && paddr == ADDR_PC)
                pc_q <= pwdata;
            if (res_valid)
            begin
                res_ctrl_q <= res_ctrl;  // Later decode wins
                res_imm_q  <= res_imm;
                res_regs_q <= res_regs;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row gives the name, the encoding fields and the expected decode
// Helper arguments are opcode or function, ALU op or subtype, operands, field and expected imm
task automatic build_table();
    int rd;
    int rj;
    int rk;
    alu_r("ADD.W", FN_ADD_W, ALU_ADD, 1, 2, 3);
    alu_r("SUB.W", FN_SUB_W, ALU_SUB, 4, 5, 6);
    alu_r("SLT", FN_SLT, ALU_SLT, 7, 8, 9);
    alu_r("SLTU", FN_SLTU, ALU_SLTU, 10, 11, 12);
    alu_r("NOR", FN_NOR, ALU_NOR, 13, 14, 15);
    alu_r("AND", FN_AND, ALU_AND, 16, 17, 18);
    alu_r("OR", FN_OR, ALU_OR, 19, 20, 21);
    alu_r("XOR", FN_XOR, ALU_XOR, 22, 23, 24);
    alu_r("SLL.W", FN_SLL_W, ALU_SLL, 25, 26, 27);
    alu_r("SRL.W", FN_SRL_W, ALU_SRL, 28, 29, 30);
    alu_r("SRA.W", FN_SRA_W, ALU_SRA, 31, 0, 1);
    for (int n = 0; n < 3; n++)
    begin
        rd = $random(seed) & 31;
        rj = $random(seed) & 31;
        rk = $random(seed) & 31;
        alu_r($sformatf("ADD.W rand %0d", n), FN_ADD_W, ALU_ADD, rd, rj, rk);
    end

    // Shift amount sits in the low five bits of the 12-bit field
    alu_i("SLLI.W", 10'b0000000001, ALU_SLL, 12'h025, 32'h0000_0005);
    alu_i("SRLI.W", 10'b0000000001, ALU_SRL, 12'h13F, 32'h0000_001F);
    alu_i("SRAI.W", 10'b0000000001, ALU_SRA, 12'h223, 32'h0000_0003);
    alu_i("SLTI", 10'b0000001000, ALU_SLT, 12'h800, 32'hFFFF_F800);
    alu_i("SLTUI", 10'b0000001001, ALU_SLTU, 12'hFFF, 32'hFFFF_FFFF);
    alu_i("ADDI.W pos", 10'b0000001010, ALU_ADD, 12'h7FF, 32'h0000_07FF);
    alu_i("ADDI.W neg", 10'b0000001010, ALU_ADD, 12'hF9C, 32'hFFFF_FF9C);
    alu_i("ANDI", 10'b0000001101, ALU_AND, 12'hF0F, 32'h0000_0F0F);
    alu_i("ORI", 10'b0000001110, ALU_OR, 12'h800, 32'h0000_0800);
    alu_i("XORI", 10'b0000001111, ALU_XOR, 12'hABC, 32'h0000_0ABC);
    upper("LU12I.W", 7'b0001010, ALU_PASS_B, 2'd0, 20'hABCDE, 32'hABCD_E000);
    upper("PCADDU12I", 7'b0001110, ALU_ADD, 2'd1, 20'h80001, 32'h8000_1000);

    mem_op("LD.B", 10'b0010100000, 0, 1'b0, 12'h004, 32'h0000_0004);
    mem_op("LD.H", 10'b0010100001, 1, 1'b0, 12'hFFE, 32'hFFFF_FFFE);
    mem_op("LD.W", 10'b0010100010, 2, 1'b0, 12'h100, 32'h0000_0100);
    mem_op("ST.B", 10'b0010100100, 3, 1'b1, 12'h801, 32'hFFFF_F801);
    mem_op("ST.H", 10'b0010100101, 4, 1'b1, 12'h002, 32'h0000_0002);
    mem_op("ST.W", 10'b0010100110, 5, 1'b1, 12'hFFC, 32'hFFFF_FFFC);
    mem_op("LD.BU", 10'b0010101000, 6, 1'b0, 12'h7FF, 32'h0000_07FF);
    mem_op("LD.HU", 10'b0010101001, 7, 1'b0, 12'h010, 32'h0000_0010);

    jirl("JIRL ret", 0, 1, 16'h0000, JK_RET, 32'h0000_0000);
    jirl("JIRL call", 1, 5, 16'h0010, JK_CALL, 32'h0000_0040);
    jirl("JIRL call ra", 1, 1, 16'h0000, JK_CALL, 32'h0000_0000);
    jirl("JIRL ra offset", 0, 1, 16'h0004, JK_INDIRECT, 32'h0000_0010);
    jirl("JIRL r0 zero", 0, 4, 16'h0000, JK_INDIRECT, 32'h0000_0000);
    jirl("JIRL indirect", 3, 4, 16'hFFFF, JK_INDIRECT, 32'hFFFF_FFFC);
    far_br("B fwd", 1'b0, 26'h000_0100, 32'h0000_0400);
    far_br("B back", 1'b0, 26'h200_0001, 32'hF800_0004);
    far_br("BL", 1'b1, 26'h001_2345, 32'h0004_8D14);
    cond_br("BEQ", OPC_BEQ, ALU_SUB, 1, 16'h0008, 32'h0000_0020);
    cond_br("BNE", OPC_BNE, ALU_SUB, 2, 16'hFFF8, 32'hFFFF_FFE0);
    cond_br("BLT", OPC_BLT, ALU_SLT, 3, 16'h0100, 32'h0000_0400);
    cond_br("BGE", OPC_BGE, ALU_SLT, 4, 16'h8000, 32'hFFFE_0000);
    cond_br("BLTU", OPC_BLTU, ALU_SLTU, 5, 16'h0001, 32'h0000_0004);
    cond_br("BGEU", OPC_BGEU, ALU_SLTU, 6, 16'h7FFF, 32'h0001_FFFC);

    excp_vec("ADEF ADD.W", 32'h1C00_0002, enc_3r(FN_ADD_W, 5'd3, 5'd2, 5'd1), EXC_ADEF);
    excp_vec("ADEF SYSCALL", 32'h1C00_0003, 32'h002B_0000, EXC_ADEF);
    excp_vec("ADEF B", 32'h1C00_0001, enc_i26(OPC_B, 26'h000_0040), EXC_ADEF);
    excp_vec("SYSCALL", PC_OK, 32'h002B_0011, EXC_SYS);
    excp_vec("BREAK", PC_OK, 32'h002A_0005, EXC_BRK);
    excp_vec("unknown op", PC_OK, 32'hFC00_0000, EXC_INE);
    excp_vec("MUL.W", PC_OK, enc_3r(7'b0111000, 5'd3, 5'd2, 5'd1), EXC_INE);
    excp_vec("CSRRD", PC_OK, 32'h0400_0000, EXC_INE);
endtask

`endif

// ==== verif/tb_decoder.sv ====
`default_nettype none

module tb_decoder;
    timeunit 1ns;
    timeprecision 100ps;
    import la32_isa_pkg::*;
    import decode_pkg::*;

    localparam logic [31:0] PC_OK = 32'h1C00_0010;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed = 21;
    int          cycles = 0;
    int          limit = 100;
    int          n_pass = 0;
    int          n_fail = 0;
    bit          test_bad;

    string       names[$];
    logic [31:0] pcs[$];
    logic [31:0] irs[$];
    logic [31:0] exp_ctrl[$];
    logic [31:0] exp_imm[$];
    logic [31:0] exp_regs[$];

    decoder_apb uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Control word fields from the MSB down with valid set
    function automatic logic [31:0] ctrl_word(logic use_rd, logic [2:0] kind, logic [3:0] op,
        logic [1:0] pcsrc, logic [1:0] src1, logic [1:0] src2, logic [4:0] sub,
        logic rw, logic mw, logic mr, logic [3:0] unit);
        return {1'b1, use_rd, kind, op, pcsrc, src1, src2, sub, rw, mw, mr, unit, 5'b0};
    endfunction

    function automatic logic [31:0] regs_word(logic [5:0] excp, logic [4:0] rk,
        logic [4:0] rj, logic [4:0] rd);
        return {11'b0, excp, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_3r(logic [6:0] fn, logic [4:0] rk, logic [4:0] rj,
        logic [4:0] rd);
        return {10'b0, fn, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(logic [5:0] op6, logic [15:0] offs,
        logic [4:0] rj, logic [4:0] rd);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i26(logic [5:0] op6, logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};  // Upper offset bits go low
    endfunction

    task automatic add_vec(string name, logic [31:0] pc, logic [31:0] ir, logic [31:0] ctrl,
        logic [31:0] imm, logic [31:0] regs);
        names.push_back(name);
        pcs.push_back(pc);
        irs.push_back(ir);
        exp_ctrl.push_back(ctrl);
        exp_imm.push_back(imm);
        exp_regs.push_back(regs);
    endtask

    task automatic alu_r(string name, logic [6:0] fn, logic [3:0] op, int rd, int rj, int rk);
        add_vec(name, PC_OK, enc_3r(fn, rk[4:0], rj[4:0], rd[4:0]),
            ctrl_word(1'b0, JK_NOT_JUMP, op, 2'd0, 2'd0, 2'd0, 5'd0, 1'b1, 1'b0, 1'b0, UNIT_ALU),
            32'h0, regs_word(EXC_NONE, rk[4:0], rj[4:0], rd[4:0]));
    endtask

    task automatic alu_i(string name, logic [9:0] op10, logic [3:0] op, logic [11:0] i12,
        logic [31:0] imm);
        add_vec(name, PC_OK, {op10, i12, 5'd7, 5'd6},
            ctrl_word(1'b0, JK_NOT_JUMP, op, 2'd0, 2'd0, 2'd1, 5'd0, 1'b1, 1'b0, 1'b0, UNIT_ALU),
            imm, regs_word(EXC_NONE, 5'd0, 5'd7, 5'd6));
    endtask

    task automatic upper(string name, logic [6:0] op7, logic [3:0] op, logic [1:0] src1,
        logic [19:0] i20, logic [31:0] imm);
        add_vec(name, PC_OK, {op7, i20, 5'd9},
            ctrl_word(1'b0, JK_NOT_JUMP, op, 2'd0, src1, 2'd1, 5'd0, 1'b1, 1'b0, 1'b0, UNIT_ALU),
            imm, regs_word(EXC_NONE, 5'd0, 5'd0, 5'd9));
    endtask

    task automatic mem_op(string name, logic [9:0] op10, int sub, logic store, logic [11:0] i12,
        logic [31:0] imm);
        add_vec(name, PC_OK, {op10, i12, 5'd11, 5'd10},
            ctrl_word(store, JK_NOT_JUMP, 4'd0, 2'd0, 2'd0, 2'd0, sub[4:0], ~store, store,
                ~store, UNIT_MEM),
            imm, regs_word(EXC_NONE, 5'd0, 5'd11, 5'd10));
    endtask

    task automatic jirl(string name, int rd, int rj, logic [15:0] offs, logic [2:0] kind,
        logic [31:0] imm);
        add_vec(name, PC_OK, enc_2ri16(OPC_JIRL, offs, rj[4:0], rd[4:0]),
            ctrl_word(1'b1, kind, ALU_ADD, 2'd1, 2'd1, 2'd3, 5'd0, 1'b1, 1'b0, 1'b0, UNIT_LINK),
            imm, regs_word(EXC_NONE, 5'd0, rj[4:0], rd[4:0]));
    endtask

    task automatic cond_br(string name, logic [5:0] op6, logic [3:0] op, int sub,
        logic [15:0] offs, logic [31:0] imm);
        add_vec(name, PC_OK, enc_2ri16(op6, offs, 5'd13, 5'd12),
            ctrl_word(1'b1, JK_DIRECT, op, 2'd1, 2'd0, 2'd2, sub[4:0], 1'b0, 1'b0, 1'b0, UNIT_BR),
            imm, regs_word(EXC_NONE, 5'd0, 5'd13, 5'd12));
    endtask

    task automatic far_br(string name, logic link, logic [25:0] offs, logic [31:0] imm);
        if (link)
            add_vec(name, PC_OK, enc_i26(OPC_BL, offs),
                ctrl_word(1'b1, JK_CALL, ALU_ADD, 2'd1, 2'd1, 2'd3, 5'd1, 1'b1, 1'b0, 1'b0,
                    UNIT_LINK),
                imm, regs_word(EXC_NONE, 5'd0, 5'd0, 5'd1));  // Link goes to ra
        else
            add_vec(name, PC_OK, enc_i26(OPC_B, offs),
                ctrl_word(1'b0, JK_JUMP, 4'd0, 2'd1, 2'd0, 2'd0, 5'd0, 1'b0, 1'b0, 1'b0,
                    UNIT_BR),
                imm, regs_word(EXC_NONE, 5'd0, 5'd0, 5'd0));
    endtask

    task automatic excp_vec(string name, logic [31:0] pc, logic [31:0] ir, logic [5:0] code);
        add_vec(name, pc, ir,
            ctrl_word(1'b0, JK_NOT_JUMP, 4'd0, 2'd0, 2'd0, 2'd0, 5'd0, 1'b0, 1'b0, 1'b0,
                UNIT_EXCP),
            32'h0, regs_word(code, 5'd0, 5'd0, 5'd0));
    endtask

    `include "tb_vectors.svh"

    // One APB transfer with read data taken at the falling edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
        output logic [31:0] rdata, output logic err, output int waits);
        waits = 0;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        logic [31:0] rd_ignored;
        int          waits_ignored;
        apb_xfer(1'b1, addr, data, rd_ignored, err, waits_ignored);
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err,
        output int waits);
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    endtask

    task automatic report_mismatch(string name, string what, logic [31:0] exp,
        logic [31:0] act);
        $display("** Error: %s %s expected 0x%08h actual 0x%08h", name, what, exp, act);
        test_bad = 1'b1;
    endtask

    task automatic report_problem(string name, string msg);
        $display("%s: %s", name, msg);
        test_bad = 1'b1;
    endtask

    task automatic finish_test(string name);
        if (test_bad)
        begin
            n_fail++;
            $display("FAIL  %s", name);
        end
        else
        begin
            n_pass++;
            $display("ok    %s", name);
        end
    endtask

    initial
    begin
        logic [31:0] rdata;
        logic        err;
        logic        err2;
        int          waits;
        clk     = 1'b0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_table();
        limit = 20 * names.size() + 100;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_bad = 1'b0;
        if (pready !== 1'b1 || pslverr !== 1'b0)
            report_problem("reset", "pready or pslverr is wrong after reset");
        apb_read(ADDR_CTRL, rdata, err, waits);
        if (rdata !== 32'h0)
            report_mismatch("reset", "ctrl", 32'h0, rdata);
        finish_test("reset");

        test_bad = 1'b0;
        apb_read(5'h14, rdata, err, waits);
        apb_write(5'h1C, 32'hDEAD_BEEF, err2);
        if (err !== 1'b1 || err2 !== 1'b1)
            report_problem("unmapped", "unmapped access did not raise pslverr");
        if (rdata !== 32'h0)
            report_mismatch("unmapped", "prdata", 32'h0, rdata);
        finish_test("unmapped");

        for (int i = 0; i < names.size(); i++)
        begin
            test_bad = 1'b0;
            apb_write(ADDR_PC, pcs[i], err);
            apb_write(ADDR_IR, irs[i], err2);
            if (err || err2)
                report_problem(names[i], "PC or IR write returned pslverr");
            apb_read(ADDR_CTRL, rdata, err, waits);
            if (waits == 0)
                report_problem(names[i], "CTRL read did not wait for the pipeline");
            if (rdata !== exp_ctrl[i])
                report_mismatch(names[i], "ctrl", exp_ctrl[i], rdata);
            apb_read(ADDR_IMM, rdata, err, waits);
            if (rdata !== exp_imm[i])
                report_mismatch(names[i], "imm", exp_imm[i], rdata);
            apb_read(ADDR_REGS, rdata, err, waits);
            if (rdata !== exp_regs[i])
                report_mismatch(names[i], "regs", exp_regs[i], rdata);
            finish_test(names[i]);
        end

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hw/la32_isa_pkg.sv
hw/decode_pkg.sv
hw/stage_ifs.sv
hw/fetch_check.sv
hw/op_decode.sv
hw/jump_classify.sv
hw/decoder_apb.sv
+incdir+verif
verif/tb_decoder.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_decoder \
    -f files.f -o tb_decoder \
    && ./obj_dir/tb_decoder | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
